// ==== verilog.f ====
+incdir+verilog
+incdir+bench
verilog/vpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/scalar_register_file.sv
verilog/vector_register_file.sv
verilog/execute_stage.sv
verilog/pipeline.sv
bench/pipeline_tb.sv

// ==== Makefile ====
# Verilator build and run for the vector pipeline testbench.

VERILATOR ?= verilator
TOP       ?= pipeline_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SOME TESTS FAILED" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/isa_model.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

////////////////////////////////////////
// Sequential instruction set model.
////////////////////////////////////////

// Runs the program in imem one instruction at a time and queues the stores.
word_t      m_sreg [`VPU_REGS];
vector_t    m_vreg [`VPU_REGS];
word_t      exp_addr [$];
vector_t    exp_data [$];
byte_mask_t exp_mask [$];

task automatic model_program();
	int         pc;
	int         lane;
	logic       running;
	word_t      ins;
	opcode_e    op;
	reg_idx_t   d;
	reg_idx_t   a;
	reg_idx_t   b;
	word_t      imm;
	word_t      addr;
	for (int r = 0; r < `VPU_REGS; r++)
	begin
		m_sreg[r] = '0;
		m_vreg[r] = '0;
	end
	exp_addr.delete();
	exp_data.delete();
	exp_mask.delete();
	pc = 0;	// Word index.
	running = 1'b1;
	while (running && pc < MEM_WORDS)
	begin
		ins = imem[pc];
		op = opcode_e'(ins[31:28]);
		d = ins[27:25];
		a = ins[24:22];
		b = ins[21:19];
		imm = {{16{ins[15]}}, ins[15:0]};
		pc = pc + 1;
		case (op)
			OP_SADD: m_sreg[d] = m_sreg[a] + m_sreg[b];
			OP_SSUB: m_sreg[d] = m_sreg[a] - m_sreg[b];
			OP_SADDI: m_sreg[d] = m_sreg[a] + imm;
			OP_VADD:
				for (int l = 0; l < `VPU_LANES; l++)
					m_vreg[d][l] = m_vreg[a][l] + m_vreg[b][l];
			OP_VADDS:
				for (int l = 0; l < `VPU_LANES; l++)
					m_vreg[d][l] = m_vreg[a][l] + m_sreg[b];
			OP_VMOVS:
				for (int l = 0; l < `VPU_LANES; l++)
					if (imm[l])
						m_vreg[d][l] = m_sreg[a];	// Other lanes keep their value.
			OP_BNZ:
				if (m_sreg[a] != '0)
					pc = pc + $signed(imm);
			OP_SST:
			begin
				addr = m_sreg[a] + imm;
				lane = int'(addr[3:2]);
				exp_addr.push_back({addr[31:4], 4'h0});
				exp_data.push_back(vector_t'(wide_t'(m_sreg[b]) << (lane * 32)));
				exp_mask.push_back(byte_mask_t'(16'h000F << (lane * 4)));
			end
			OP_VST:
			begin
				addr = m_sreg[a] + imm;
				exp_addr.push_back({addr[31:4], 4'h0});
				exp_data.push_back(m_vreg[b]);
				exp_mask.push_back('1);
			end
			OP_HALT: running = 1'b0;
			default:
			begin
			end
		endcase
	end
endtask

`endif

// ==== bench/pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vpu_config.svh"

module pipeline_tb;
	import vpu_pkg::*;

	localparam int PROGRAMS = 20;
	localparam int PROG_LEN = 40;
	localparam int MEM_WORDS = 64;
	localparam int TIMEOUT_CYCLES = PROGRAMS * (3 * PROG_LEN + 30);

	typedef logic [127:0] wide_t;

	logic       clk = 1'b0;
	logic       rst_n_i = 1'b0;
	word_t      iaddress;
	logic       iaccess;
	word_t      idata = '0;
	logic       dwrite;
	word_t      daddress;
	vector_t    ddata;
	byte_mask_t dwrite_mask;
	logic       halted;
	word_t      imem [MEM_WORDS];
	int         cycles = 0;
	int         stores_seen = 0;

	`include "isa_model.svh"

	pipeline UUT (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.iaddress_o(iaddress),
		.iaccess_o(iaccess),
		.idata_i(idata),
		.dwrite_o(dwrite),
		.daddress_o(daddress),
		.ddata_o(ddata),
		.dwrite_mask_o(dwrite_mask),
		.halted_o(halted));

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		if (iaccess)
			idata <= imem[iaddress[7:2]];	// Word arrives one cycle after the request.
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			stop_run($sformatf("Timeout: the run took more than %0d cycles", TIMEOUT_CYCLES));
	end

	////////////////////////////////////////
	// Checks.
	////////////////////////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped.");
	endtask

	task automatic compare_values(input wide_t got, input wide_t expected, input string what);
		if (got !== expected)
		begin
			$display("MISMATCH at time %0t: %s, got %h, expected %h", $time, what, got, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "Run stopped.");
		end
	endtask

	function automatic wide_t byte_bits(input byte_mask_t mask);
		wide_t bits;
		for (int i = 0; i < 16; i++)
			bits[i*8 +: 8] = {8{mask[i]}};
		return bits;
	endfunction

	task automatic check_store(input int prog);
		wide_t keep;
		if (exp_addr.size() == 0)
			stop_run($sformatf("Program %0d made a store to %h that the model does not make",
				prog, daddress));
		else
		begin
			keep = byte_bits(exp_mask[0]);	// Bytes outside the mask are don't care.
			compare_values(wide_t'(daddress), wide_t'(exp_addr[0]), "store address");
			compare_values(wide_t'(dwrite_mask), wide_t'(exp_mask[0]), "store byte mask");
			compare_values(wide_t'(ddata) & keep, wide_t'(exp_data[0]) & keep, "store data");
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
			void'(exp_mask.pop_front());
			stores_seen++;
		end
	endtask

	////////////////////////////////////////
	// Programs.
	////////////////////////////////////////

	task automatic make_program();
		opcode_e     op;
		logic [15:0] imm;
		int          lim;
		for (int i = 0; i < MEM_WORDS; i++)
			imem[i] = '0;
		for (int i = 0; i < PROG_LEN - 1; i++)
		begin
			case ($urandom % 12)
				0: op = OP_NOP;
				1: op = OP_SADD;
				2: op = OP_SSUB;
				3, 4: op = OP_SADDI;
				5: op = OP_VADD;
				6: op = OP_VADDS;
				7: op = OP_VMOVS;
				8: op = OP_BNZ;
				9, 10: op = OP_SST;
				default: op = OP_VST;
			endcase
			case (op)
				OP_SADDI: imm = 16'($urandom % 512) - 16'd256;
				OP_VMOVS: imm = 16'($urandom % 16);
				OP_BNZ:
				begin
					lim = (PROG_LEN - 2 - i < 3) ? PROG_LEN - 2 - i : 3;	// Forward and never past HALT.
					imm = 16'($urandom % (lim + 1));
				end
				OP_SST, OP_VST: imm = 16'($urandom % 64);
				default: imm = '0;
			endcase
			imem[i] = {op, 3'($urandom % 8), 3'($urandom % 8), 3'($urandom % 8), 3'b000, imm};
		end
		imem[PROG_LEN-1] = {OP_HALT, 28'h0};
	endtask

	task automatic start_program();
		@(posedge clk);
		rst_n_i <= 1'b0;
		make_program();
		model_program();
		repeat (3) @(posedge clk);
		rst_n_i <= 1'b1;
		@(negedge clk);
		compare_values(wide_t'(dwrite), '0, "dwrite after reset");
		compare_values(wide_t'(halted), '0, "halted after reset");
		compare_values(wide_t'(iaccess), wide_t'(1'b1), "iaccess after reset");
		compare_values(wide_t'(iaddress), wide_t'(`VPU_RESET_PC), "first fetch address");
	endtask

	task automatic run_program(input int prog);
		while (!halted)
		begin
			if (dwrite)
				check_store(prog);
			@(negedge clk);
		end
		if (exp_addr.size() != 0)
			stop_run($sformatf("Program %0d halted with %0d of its stores not seen",
				prog, exp_addr.size()));
		else
		begin
			repeat (4)
			begin
				compare_values(wide_t'(dwrite), '0, "store after halt");
				compare_values(wide_t'(iaccess), '0, "fetch after halt");
				@(negedge clk);
			end
		end
	endtask

	initial
	begin
		void'($urandom(32'h2912));
		for (int p = 0; p < PROGRAMS; p++)
		begin
			start_program();
			run_program(p);
		end
		$display("%0d programs run, %0d stores checked", PROGRAMS, stores_seen);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline (
	input  wire                       clk,
	input  wire                       rst_n_i,
	output wire vpu_pkg::word_t       iaddress_o,
	output wire                       iaccess_o,
	input  wire vpu_pkg::word_t       idata_i,
	output wire                       dwrite_o,
	output wire vpu_pkg::word_t       daddress_o,
	output wire vpu_pkg::vector_t     ddata_o,
	output wire vpu_pkg::byte_mask_t  dwrite_mask_o,
	output wire                       halted_o
);
	import vpu_pkg::*;

	wire word_t      if_pc;
	wire             if_valid;
	wire reg_idx_t   ssel1;
	wire reg_idx_t   ssel2;
	wire reg_idx_t   vsel1;
	wire reg_idx_t   vsel2;
	wire opcode_e    dc_op;
	wire reg_idx_t   dc_dest;
	wire word_t      dc_imm;
	wire word_t      dc_pc;
	wire             dc_valid;
	wire word_t      svalue1;
	wire word_t      svalue2;
	wire vector_t    vvalue1;
	wire vector_t    vvalue2;
	wire             wb_valid;
	wire             wb_is_vector;
	wire reg_idx_t   wb_reg;
	wire vector_t    wb_value;
	wire lane_mask_t wb_mask;
	wire             restart;
	wire word_t      restart_pc;
	wire             flush;
	wire             scalar_we;
	wire             vector_we;

	assign scalar_we = wb_valid && !wb_is_vector;
	assign vector_we = wb_valid && wb_is_vector;

	fetch_stage ifs (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.restart_i(restart),
		.restart_pc_i(restart_pc),
		.halt_i(halted_o),
		.iaddress_o(iaddress_o),
		.iaccess_o(iaccess_o),
		.pc_o(if_pc),
		.valid_o(if_valid));

	decode_stage ds (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.instr_i(idata_i),
		.valid_i(if_valid),
		.pc_i(if_pc),
		.flush_i(flush),
		.ssel1_o(ssel1),
		.ssel2_o(ssel2),
		.vsel1_o(vsel1),
		.vsel2_o(vsel2),
		.op_o(dc_op),
		.dest_o(dc_dest),
		.imm_o(dc_imm),
		.pc_o(dc_pc),
		.valid_o(dc_valid));

	scalar_register_file srf (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.sel1_i(ssel1),
		.sel2_i(ssel2),
		.value1_o(svalue1),
		.value2_o(svalue2),
		.write_en_i(scalar_we),
		.write_reg_i(wb_reg),
		.write_value_i(wb_value[0]));	// Scalars travel in lane 0.

	vector_register_file vrf (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.sel1_i(vsel1),
		.sel2_i(vsel2),
		.value1_o(vvalue1),
		.value2_o(vvalue2),
		.write_en_i(vector_we),
		.write_reg_i(wb_reg),
		.write_value_i(wb_value),
		.write_mask_i(wb_mask));

	execute_stage exs (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.op_i(dc_op),
		.dest_i(dc_dest),
		.imm_i(dc_imm),
		.pc_i(dc_pc),
		.valid_i(dc_valid),
		.svalue1_i(svalue1),
		.svalue2_i(svalue2),
		.vvalue1_i(vvalue1),
		.vvalue2_i(vvalue2),
		.ssel1_i(ssel1),
		.ssel2_i(ssel2),
		.vsel1_i(vsel1),
		.vsel2_i(vsel2),
		.wb_valid_o(wb_valid),
		.wb_is_vector_o(wb_is_vector),
		.wb_reg_o(wb_reg),
		.wb_value_o(wb_value),
		.wb_mask_o(wb_mask),
		.restart_o(restart),
		.restart_pc_o(restart_pc),
		.flush_o(flush),
		.halted_o(halted_o),
		.dwrite_o(dwrite_o),
		.daddress_o(daddress_o),
		.ddata_o(ddata_o),
		.dwrite_mask_o(dwrite_mask_o));

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vpu_config.svh"

module execute_stage (
	input  wire                      clk,
	input  wire                      rst_n_i,
	input  wire vpu_pkg::opcode_e    op_i,
	input  wire vpu_pkg::reg_idx_t   dest_i,
	input  wire vpu_pkg::word_t      imm_i,
	input  wire vpu_pkg::word_t      pc_i,
	input  wire                      valid_i,
	input  wire vpu_pkg::word_t      svalue1_i,
	input  wire vpu_pkg::word_t      svalue2_i,
	input  wire vpu_pkg::vector_t    vvalue1_i,
	input  wire vpu_pkg::vector_t    vvalue2_i,
	input  wire vpu_pkg::reg_idx_t   ssel1_i,
	input  wire vpu_pkg::reg_idx_t   ssel2_i,
	input  wire vpu_pkg::reg_idx_t   vsel1_i,
	input  wire vpu_pkg::reg_idx_t   vsel2_i,
	output logic                     wb_valid_o,
	output logic                     wb_is_vector_o,
	output vpu_pkg::reg_idx_t        wb_reg_o,
	output vpu_pkg::vector_t         wb_value_o,
	output vpu_pkg::lane_mask_t      wb_mask_o,
	output logic                     restart_o,
	output vpu_pkg::word_t           restart_pc_o,
	output logic                     flush_o,
	output logic                     halted_o,
	output logic                     dwrite_o,
	output vpu_pkg::word_t           daddress_o,
	output vpu_pkg::vector_t         ddata_o,
	output vpu_pkg::byte_mask_t      dwrite_mask_o
);
	import vpu_pkg::*;

	reg_idx_t   ssel1_l;	// Selects aligned with the file outputs.
	reg_idx_t   ssel2_l;
	reg_idx_t   vsel1_l;
	reg_idx_t   vsel2_l;
	logic       old_valid;
	logic       old_is_vector;
	reg_idx_t   old_reg;
	vector_t    old_value;
	lane_mask_t old_mask;
	logic       live;
	word_t      s1;
	word_t      s2;
	vector_t    v1;
	vector_t    v2;
	logic       has_wb;
	logic       res_is_vector;
	vector_t    result;
	lane_mask_t res_mask;
	logic       store;
	word_t      store_addr;
	vector_t    store_data;
	byte_mask_t store_mask;

	function automatic word_t bypass_scalar(input reg_idx_t sel, input word_t file_value);
		if (wb_valid_o && !wb_is_vector_o && wb_reg_o == sel)
			return wb_value_o[0];
		if (old_valid && !old_is_vector && old_reg == sel)
			return old_value[0];
		return file_value;
	endfunction

	// Newer lanes overwrite older ones.
	function automatic vector_t bypass_vector(input reg_idx_t sel, input vector_t file_value);
		vector_t merged;
		merged = file_value;
		for (int l = 0; l < `VPU_LANES; l++)
		begin
			if (old_valid && old_is_vector && old_reg == sel && old_mask[l])
				merged[l] = old_value[l];
			if (wb_valid_o && wb_is_vector_o && wb_reg_o == sel && wb_mask_o[l])
				merged[l] = wb_value_o[l];
		end
		return merged;
	endfunction

	assign live = valid_i && !halted_o;	// Nothing retires after a halt.

	always_comb
	begin
		s1 = bypass_scalar(ssel1_l, svalue1_i);
		s2 = bypass_scalar(ssel2_l, svalue2_i);
		v1 = bypass_vector(vsel1_l, vvalue1_i);
		v2 = bypass_vector(vsel2_l, vvalue2_i);
	end

	assign store_addr = s1 + imm_i;

	assign restart_o = live && op_i == OP_BNZ && s1 != '0;
	assign restart_pc_o = pc_i + 32'd4 + (imm_i << 2);
	assign flush_o = restart_o;

	////////////////////////////////////////
	// ALU and store formatting.
	////////////////////////////////////////

	always_comb
	begin
		has_wb = 1'b0;
		res_is_vector = 1'b0;
		res_mask = lane_mask_t'(1);
		result = '0;
		store = 1'b0;
		store_data = '0;
		store_mask = '0;
		if (live)
		begin
			case (op_i)
				OP_SADD:
				begin
					has_wb = 1'b1;
					result[0] = s1 + s2;
				end
				OP_SSUB:
				begin
					has_wb = 1'b1;
					result[0] = s1 - s2;
				end
				OP_SADDI:
				begin
					has_wb = 1'b1;
					result[0] = s1 + imm_i;
				end
				OP_VADD, OP_VADDS:
				begin
					has_wb = 1'b1;
					res_is_vector = 1'b1;
					res_mask = '1;
					for (int l = 0; l < `VPU_LANES; l++)
						result[l] = v1[l] + ((op_i == OP_VADD) ? v2[l] : s2);
				end
				OP_VMOVS:
				begin
					has_wb = |imm_i[`VPU_LANES-1:0];	// Empty mask writes nothing.
					res_is_vector = 1'b1;
					res_mask = imm_i[`VPU_LANES-1:0];
					result = {`VPU_LANES{s1}};
				end
				OP_SST:
				begin
					store = 1'b1;
					store_data[store_addr[3:2]] = s2;
					store_mask[{store_addr[3:2], 2'b00} +: 4] = 4'hF;
				end
				OP_VST:
				begin
					store = 1'b1;
					store_data = v2;
					store_mask = '1;
				end
				default:
				begin
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Output flops.
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wb_valid_o <= 1'b0;
			old_valid <= 1'b0;
			dwrite_o <= 1'b0;
			halted_o <= 1'b0;
		end
		else
		begin
			wb_valid_o <= has_wb;
			old_valid <= wb_valid_o;
			dwrite_o <= store;
			if (live && op_i == OP_HALT)
				halted_o <= 1'b1;	// Held until reset.
		end
	end

	always_ff @(posedge clk)
	begin
		ssel1_l <= ssel1_i;
		ssel2_l <= ssel2_i;
		vsel1_l <= vsel1_i;
		vsel2_l <= vsel2_i;
		wb_is_vector_o <= res_is_vector;
		wb_reg_o <= dest_i;
		wb_value_o <= result;
		wb_mask_o <= res_mask;

		// The file write at this edge is not yet visible to reads made at it.
		old_is_vector <= wb_is_vector_o;
		old_reg <= wb_reg_o;
		old_value <= wb_value_o;
		old_mask <= wb_mask_o;

		daddress_o <= {store_addr[`VPU_WORD_BITS-1:4], 4'b0000};
		ddata_o <= store_data;
		dwrite_mask_o <= store_mask;
	end

	a_store_or_writeback: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(dwrite_o && wb_valid_o));

endmodule

`default_nettype wire

// ==== verilog/vector_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vpu_config.svh"

module vector_register_file (
	input  wire                      clk,
	input  wire                      rst_n_i,
	input  wire vpu_pkg::reg_idx_t   sel1_i,
	input  wire vpu_pkg::reg_idx_t   sel2_i,
	output vpu_pkg::vector_t         value1_o,
	output vpu_pkg::vector_t         value2_o,
	input  wire                      write_en_i,
	input  wire vpu_pkg::reg_idx_t   write_reg_i,
	input  wire vpu_pkg::vector_t    write_value_i,
	input  wire vpu_pkg::lane_mask_t write_mask_i
);
	import vpu_pkg::*;

	vector_t regs [`VPU_REGS];

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < `VPU_REGS; i++)
				regs[i] <= '0;
		end
		else if (write_en_i)
		begin
			for (int l = 0; l < `VPU_LANES; l++)
			begin
				if (write_mask_i[l])
					regs[write_reg_i][l] <= write_value_i[l];	// Unmasked lanes hold.
			end
		end
	end

	always_ff @(posedge clk)
	begin
		value1_o <= regs[sel1_i];
		value2_o <= regs[sel2_i];
	end

	a_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
		write_en_i |-> (write_mask_i != '0));

endmodule

`default_nettype wire

// ==== verilog/scalar_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vpu_config.svh"

module scalar_register_file (
	input  wire                    clk,
	input  wire                    rst_n_i,
	input  wire vpu_pkg::reg_idx_t sel1_i,
	input  wire vpu_pkg::reg_idx_t sel2_i,
	output vpu_pkg::word_t         value1_o,
	output vpu_pkg::word_t         value2_o,
	input  wire                    write_en_i,
	input  wire vpu_pkg::reg_idx_t write_reg_i,
	input  wire vpu_pkg::word_t    write_value_i
);
	import vpu_pkg::*;

	word_t regs [`VPU_REGS];

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < `VPU_REGS; i++)
				regs[i] <= '0;
		end
		else if (write_en_i)
			regs[write_reg_i] <= write_value_i;
	end

	// A read at the write edge returns the old value.
	always_ff @(posedge clk)
	begin
		value1_o <= regs[sel1_i];
		value2_o <= regs[sel2_i];
	end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vpu_config.svh"

module decode_stage (
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  wire vpu_pkg::word_t   instr_i,
	input  wire                   valid_i,
	input  wire vpu_pkg::word_t   pc_i,
	input  wire                   flush_i,
	output vpu_pkg::reg_idx_t     ssel1_o,
	output vpu_pkg::reg_idx_t     ssel2_o,
	output vpu_pkg::reg_idx_t     vsel1_o,
	output vpu_pkg::reg_idx_t     vsel2_o,
	output vpu_pkg::opcode_e      op_o,
	output vpu_pkg::reg_idx_t     dest_o,
	output vpu_pkg::word_t        imm_o,
	output vpu_pkg::word_t        pc_o,
	output logic                  valid_o
);
	import vpu_pkg::*;

	opcode_e  opcode;
	reg_idx_t dest;
	reg_idx_t src1;
	reg_idx_t src2;
	imm_t     imm;
	logic     keep;

	assign opcode = opcode_e'(instr_i[31:28]);
	assign dest = instr_i[27:25];
	assign src1 = instr_i[24:22];
	assign src2 = instr_i[21:19];
	assign imm = instr_i[15:0];
	assign keep = valid_i && !flush_i;

	// Both files read src1 and src2 every cycle.
	assign ssel1_o = src1;
	assign ssel2_o = src2;
	assign vsel1_o = src1;
	assign vsel2_o = src2;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			op_o <= OP_NOP;
			valid_o <= 1'b0;
		end
		else
		begin
			op_o <= keep ? opcode : OP_NOP;	// Bubble for empty or flushed slots.
			valid_o <= keep;
		end
	end

	always_ff @(posedge clk)
	begin
		dest_o <= dest;
		imm_o <= {{(`VPU_WORD_BITS-16){imm[15]}}, imm};
		pc_o <= pc_i;
	end

	a_opcode_defined: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_i |-> (instr_i[31:28] <= OP_HALT));

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vpu_config.svh"

module fetch_stage (
	input  wire                 clk,
	input  wire                 rst_n_i,
	input  wire                 restart_i,
	input  wire vpu_pkg::word_t restart_pc_i,
	input  wire                 halt_i,
	output vpu_pkg::word_t      iaddress_o,
	output logic                iaccess_o,
	output vpu_pkg::word_t      pc_o,
	output logic                valid_o
);
	import vpu_pkg::*;

	word_t pc;

	assign iaddress_o = pc;
	assign iaccess_o = !halt_i;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			pc <= `VPU_RESET_PC;
			valid_o <= 1'b0;
		end
		else
		begin
			if (restart_i)
				pc <= restart_pc_i;	// Target goes out next cycle.
			else if (iaccess_o)
				pc <= pc + 32'd4;

			// Word requested during a restart is no longer wanted.
			valid_o <= iaccess_o && !restart_i;
		end
	end

	// Address of the word arriving on idata.
	always_ff @(posedge clk)
	begin
		pc_o <= pc;
	end

	a_no_fetch_halted: assert property (@(posedge clk) disable iff (!rst_n_i)
		halt_i |=> !valid_o && $stable(pc));

endmodule

`default_nettype wire

// ==== verilog/vpu_pkg.sv ====
`default_nettype none

`include "vpu_config.svh"

package vpu_pkg;

	typedef logic [`VPU_WORD_BITS-1:0] word_t;
	typedef word_t [`VPU_LANES-1:0] vector_t;	// Lane 0 in the low bits.
	typedef logic [$clog2(`VPU_REGS)-1:0] reg_idx_t;
	typedef logic [`VPU_LANES-1:0] lane_mask_t;
	typedef logic [`VPU_LANES*`VPU_WORD_BITS/8-1:0] byte_mask_t;	// One bit per store byte.
	typedef logic signed [15:0] imm_t;

	////////////////////////////////////////
	// Opcodes in instruction bits 31:28.
	////////////////////////////////////////

	typedef enum logic [3:0] {
		OP_NOP   = 4'h0,
		OP_SADD  = 4'h1,
		OP_SSUB  = 4'h2,
		OP_SADDI = 4'h3,
		OP_VADD  = 4'h4,
		OP_VADDS = 4'h5,
		OP_VMOVS = 4'h6,	// Lane mask in imm[3:0].
		OP_BNZ   = 4'h7,
		OP_SST   = 4'h8,
		OP_VST   = 4'h9,
		OP_HALT  = 4'hA
	} opcode_e;

endpackage

`default_nettype wire

// ==== verilog/vpu_config.svh ====
`ifndef VPU_CONFIG_SVH
`define VPU_CONFIG_SVH

////////////////////////////////////////
// Register file shape.
////////////////////////////////////////

`define VPU_LANES      4
`define VPU_REGS       8
`define VPU_WORD_BITS  32

////////////////////////////////////////
// Fetch.
////////////////////////////////////////

`define VPU_RESET_PC   32'h0000_0000	// First fetch address.

`endif
